/* tb/script_cases.txt */
# case nwords words | fb_init fb_switch switch_cycle | tick_idx tick_n cond_idx | nexp bytes | gs
# all hex; byte 0xx is target, 1xx is operate; ff marks an unused index or cycle
# action words, invalid codes and func 2 give nothing
case b 000c 0501 0009 0109 0509 0209 0309 0409 0111 2a01 001c 0 0 ff ff 0 ff 7 015 142 122 112 10a 106 0a9 3
# jumps func 0..3 with hand high
case d 062a 0501 0109 0009 0e12 0109 0209 021a 02aa 0409 1802 0309 001c 2 2 ff ff 0 ff 2 142 106 3
# timed wait of 5 ticks
case 4 0501 0503 0209 001c 0 0 ff 1 5 ff 2 015 112 3
# condition wait on machine, pause then finish
case 5 0109 006b 0409 0014 001c 0 8 1e ff 0 1 2 122 106 3

/* compile.f */
hdl/script_pkg.sv
hdl/script_mem.sv
hdl/script_sequencer.sv
hdl/action_formatter.sv
hdl/jump_unit.sv
hdl/wait_unit.sv
hdl/script_top.sv
tb/tb_clock.sv
tb/script_chk.sv
tb/script_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= script_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Test passed" $(LOG) || (echo "simulation gave no result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/script_tb.sv */
//######################################################################
// script interpreter testbench
//######################################################################
`timescale 1ns/1ps
`default_nettype none

module script_tb;
    import script_pkg::*;

    localparam int run_limit = 3000;
    localparam int wait_limit = 100;
    localparam int max_words = 32;
    localparam int max_bytes = 16;

    logic              next_step;
    logic              rst;
    logic              reset_req;
    logic              load_en;
    logic [pc_w-1:0]   load_addr;
    logic [word_w-1:0] load_data;
    logic              start;
    logic [3:0]        fb;
    logic              ms_tick;
    logic              target_valid;
    logic [7:0]        target;
    logic              operate_valid;
    logic [7:0]        operate;
    game_state_e       game_state;
    logic [pc_w-1:0]   pc;
    logic              busy;
    logic              halted;

    // case data, bytes carry bit 8 set for operate
    logic [15:0] prog [max_words];
    logic [8:0]  exp_bytes [max_bytes];
    int n_words;
    int n_exp;
    int fb_init;
    int fb_switch;
    int sw_cycle;
    int tick_idx;
    int tick_n;
    int cond_idx;
    int exp_gs;
    int fd;
    int case_no;
    int n_seen;
    int tick_cnt;
    int gap;
    bit switched;
    logic [31:0] lfsr;
    // game state last seen and next program word to scan for a game word
    logic [1:0] gs_now;
    int gw_idx;

    tb_clock u_clock (
        .i_reset_req (reset_req),
        .next_step   (next_step),
        .rst         (rst)
    );

    // fb bit order front, hand, processing, machine
    script_top u_script_top (
        .next_step        (next_step),
        .rst              (rst),
        .i_load_en        (load_en),
        .i_load_addr      (load_addr),
        .i_load_data      (load_data),
        .i_start          (start),
        .i_sig_front      (fb[0]),
        .i_sig_hand       (fb[1]),
        .i_sig_processing (fb[2]),
        .i_sig_machine    (fb[3]),
        .i_ms_tick        (ms_tick),
        .o_target_valid   (target_valid),
        .o_target         (target),
        .o_operate_valid  (operate_valid),
        .o_operate        (operate),
        .o_game_state     (game_state),
        .o_pc             (pc),
        .o_busy           (busy),
        .o_halted         (halted)
    );

    // galois lfsr, one step per bit taken
    function automatic logic next_rand_bit();
        logic out;
        out = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return out;
    endfunction

    // tick spacing 1..8 cycles
    function automatic int rand_gap();
        int g;
        g = 0;
        for (int i = 0; i < 3; i++) begin
            g = (g << 1) | int'(next_rand_bit());
        end
        return g + 1;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic compare_val(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            abort_run("output mismatch");
        end
    endtask

    task automatic check_idle();
        @(negedge next_step);
        compare_val("o_target_valid", 32'(target_valid), 32'd0);
        compare_val("o_operate_valid", 32'(operate_valid), 32'd0);
        compare_val("o_busy", 32'(busy), 32'd0);
        compare_val("o_halted", 32'(halted), 32'd0);
        compare_val("o_pc", 32'(pc), 32'd0);
        compare_val("o_game_state", 32'(game_state), 32'(gs_idle));
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (rst !== 1'b0) begin
            @(posedge next_step);
            n++;
            if (n > wait_limit) begin
                abort_run("reset never released");
            end
        end
        check_idle();
    endtask

    task automatic apply_reset();
        int n;
        n = 0;
        @(posedge next_step);
        reset_req <= 1'b1;
        @(posedge next_step);
        reset_req <= 1'b0;
        while (!rst) begin
            @(posedge next_step);
            n++;
            if (n > wait_limit) begin
                abort_run("reset request not honored");
            end
        end
        wait_reset_release();
    endtask

    // skips comment lines, fills the case variables
    task automatic read_case(output bit got);
        string tok;
        string rest;
        int r;
        bit done;
        got = 1'b0;
        done = 1'b0;
        while (!done) begin
            r = $fscanf(fd, " %s", tok);
            if (r != 1) begin
                done = 1'b1;
            end else if (tok == "case") begin
                r = $fscanf(fd, " %h", n_words);
                if (n_words > max_words) begin
                    abort_run("program in cases file too long");
                end
                for (int i = 0; i < n_words; i++) begin
                    r = $fscanf(fd, " %h", prog[i]);
                end
                r = $fscanf(fd, " %h %h %h", fb_init, fb_switch, sw_cycle);
                r = $fscanf(fd, " %h %h %h", tick_idx, tick_n, cond_idx);
                r = $fscanf(fd, " %h", n_exp);
                if (n_exp > max_bytes) begin
                    abort_run("too many expected bytes in cases file");
                end
                for (int i = 0; i < n_exp; i++) begin
                    r = $fscanf(fd, " %h", exp_bytes[i]);
                end
                r = $fscanf(fd, " %h", exp_gs);
                if (r != 1) begin
                    abort_run("cases file ends inside a case");
                end
                got = 1'b1;
                done = 1'b1;
            end else begin
                r = $fgets(rest, fd);
            end
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < n_words; i++) begin
            @(posedge next_step);
            load_en   <= 1'b1;
            load_addr <= pc_w'(i * 2);
            load_data <= prog[i];
        end
        @(posedge next_step);
        load_en <= 1'b0;
        fb      <= 4'(fb_init);
    endtask

    task automatic record_byte(input logic [8:0] b);
        if (n_seen >= n_exp) begin
            abort_run("command byte appeared that the case does not expect");
        end
        compare_val("command byte", 32'(b), 32'(exp_bytes[n_seen]));
        if (n_seen == tick_idx && tick_cnt < tick_n) begin
            abort_run("command came out before the timed wait got its ticks");
        end
        if (n_seen == cond_idx && !switched) begin
            abort_run("command came out before the wait condition held");
        end
        // ticks count from the byte before the wait
        if (n_seen + 1 == tick_idx) begin
            tick_cnt = 0;
        end
        n_seen++;
    endtask

    // game words in program order give each expected state change
    task automatic check_game_state();
        logic [1:0] want;
        want = gs_now;
        if (game_state != gs_now) begin
            while (gw_idx < n_words && want == gs_now) begin
                if (prog[gw_idx][2:0] == op_game) begin
                    want = prog[gw_idx][4:3];
                end
                gw_idx++;
            end
            compare_val("o_game_state", 32'(game_state), 32'(want));
            gs_now = want;
        end
    endtask

    task automatic run_case();
        int cyc;
        bit stop;
        n_seen = 0;
        tick_cnt = 0;
        switched = 1'b0;
        gs_now = gs_idle;
        gw_idx = 0;
        gap = rand_gap();
        cyc = 0;
        stop = 1'b0;
        @(posedge next_step);
        start <= 1'b1;
        while (!stop) begin
            @(posedge next_step);
            start <= 1'b0;
            cyc++;
            if (cyc > run_limit) begin
                abort_run("script did not halt in time");
            end
            // a tick driven last cycle is sampled on this edge
            if (ms_tick) begin
                tick_cnt++;
            end
            if (cyc > sw_cycle) begin
                switched = 1'b1;
            end
            gap--;
            if (gap == 0) begin
                ms_tick <= 1'b1;
                gap = rand_gap();
            end else begin
                ms_tick <= 1'b0;
            end
            if (cyc == sw_cycle) begin
                fb <= 4'(fb_switch);
            end
            @(negedge next_step);
            if (target_valid) begin
                record_byte({1'b0, target});
            end
            if (operate_valid) begin
                record_byte({1'b1, operate});
            end
            // running from the cycle after start until halt
            if (!halted) begin
                compare_val("o_busy", 32'(busy), 32'd1);
            end
            check_game_state();
            stop = halted;
        end
        compare_val("o_busy", 32'(busy), 32'd0);
        compare_val("o_game_state", 32'(game_state), 32'(exp_gs));
        compare_val("command count", 32'(n_seen), 32'(n_exp));
        // nothing more once halted
        repeat (10) begin
            @(negedge next_step);
            compare_val("o_target_valid", 32'(target_valid), 32'd0);
            compare_val("o_operate_valid", 32'(operate_valid), 32'd0);
            compare_val("o_halted", 32'(halted), 32'd1);
        end
        @(posedge next_step);
        ms_tick <= 1'b0;
    endtask

    initial begin
        bit got;
        reset_req = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        start     = 1'b0;
        fb        = 4'd0;
        ms_tick   = 1'b0;
        lfsr      = 32'hd4d1;
        case_no   = 0;
        fd = $fopen("tb/script_cases.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open tb/script_cases.txt");
        end
        wait_reset_release();
        read_case(got);
        while (got) begin
            if (case_no > 0) begin
                apply_reset();
            end
            load_program();
            run_case();
            case_no++;
            read_case(got);
        end
        $fclose(fd);
        if (case_no == 0) begin
            abort_run("no cases found in cases file");
        end else begin
            $display("Test passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/script_chk.sv */
//######################################################################
// sequencer assertions
//######################################################################
`timescale 1ns/1ps
`default_nettype none

module script_chk (
    input wire logic       next_step,
    input wire logic       rst,
    input wire logic       o_act_en,
    input wire logic       o_jump_en,
    input wire logic       o_wait_start,
    input wire logic [7:0] o_pc,
    input wire logic       o_busy,
    input wire logic       o_halted
);
    // at most one unit started per exec cycle
    a_one_unit: assert property (@(posedge next_step) disable iff (rst)
        $onehot0({o_act_en, o_jump_en, o_wait_start}))
        else $error("unit enables high together");

    // byte address stays word aligned
    a_pc_aligned: assert property (@(posedge next_step) disable iff (rst) !o_pc[0])
        else $error("pc bit 0 set");

    a_halt_idle: assert property (@(posedge next_step) disable iff (rst) o_halted |-> !o_busy)
        else $error("busy while halted");

endmodule

bind script_sequencer script_chk u_chk (
    .next_step    (next_step),
    .rst          (rst),
    .o_act_en     (o_act_en),
    .o_jump_en    (o_jump_en),
    .o_wait_start (o_wait_start),
    .o_pc         (o_pc),
    .o_busy       (o_busy),
    .o_halted     (o_halted)
);

`default_nettype wire

/* tb/tb_clock.sv */
//######################################################################
// testbench clock and reset
//######################################################################
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    input  wire logic i_reset_req,
    output      logic next_step,
    output      logic rst
);
    // 4 ns period
    initial begin
        next_step = 1'b0;
        forever #2 next_step = ~next_step;
    end

    // reset held 8 cycles at power up and on every request
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge next_step);
        rst <= 1'b0;
        forever begin
            @(posedge i_reset_req);
            rst <= 1'b1;
            repeat (8) @(posedge next_step);
            rst <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hdl/script_top.sv */
//####################################################################
// script interpreter top
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module script_top (
    input  wire logic                          next_step,
    input  wire logic                          rst,
    input  wire logic                          i_load_en,
    input  wire logic [script_pkg::pc_w-1:0]   i_load_addr,
    input  wire logic [script_pkg::word_w-1:0] i_load_data,
    input  wire logic                          i_start,
    input  wire logic                          i_sig_front,
    input  wire logic                          i_sig_hand,
    input  wire logic                          i_sig_processing,
    input  wire logic                          i_sig_machine,
    input  wire logic                          i_ms_tick,
    output      logic                          o_target_valid,
    output      logic [7:0]                    o_target,
    output      logic                          o_operate_valid,
    output      logic [7:0]                    o_operate,
    output      script_pkg::game_state_e       o_game_state,
    output      logic [script_pkg::pc_w-1:0]   o_pc,
    output      logic                          o_busy,
    output      logic                          o_halted
);
    import script_pkg::*;

    logic [pc_w-1:0]   mem_rd_addr;
    logic [word_w-1:0] rd_data;
    logic [num_w-1:0]  num;
    logic [sel_w-1:0]  sel;
    logic [func_w-1:0] func;
    logic              act_en;
    logic              jump_en;
    logic              wait_start;
    logic              jump_taken;
    logic [pc_w-1:0]   jump_target;
    logic              wait_done;

    script_mem u_mem (
        .next_step (next_step),
        .i_we      (i_load_en),
        .i_wr_addr (i_load_addr),
        .i_wr_data (i_load_data),
        .i_rd_addr (mem_rd_addr),
        .o_rd_data (rd_data)
    );

    script_sequencer u_seq (
        .next_step     (next_step),
        .rst           (rst),
        .i_start       (i_start),
        .i_rd_data     (rd_data),
        .i_jump_taken  (jump_taken),
        .i_jump_target (jump_target),
        .i_wait_done   (wait_done),
        .o_rd_addr     (mem_rd_addr),
        .o_num         (num),
        .o_sel         (sel),
        .o_func        (func),
        .o_act_en      (act_en),
        .o_jump_en     (jump_en),
        .o_wait_start  (wait_start),
        .o_game_state  (o_game_state),
        .o_pc          (o_pc),
        .o_busy        (o_busy),
        .o_halted      (o_halted)
    );

    action_formatter u_act (
        .next_step       (next_step),
        .rst             (rst),
        .i_en            (act_en),
        .i_num           (num),
        .i_func          (func),
        .o_target_valid  (o_target_valid),
        .o_target        (o_target),
        .o_operate_valid (o_operate_valid),
        .o_operate       (o_operate)
    );

    // feedback goes straight to both condition users
    jump_unit u_jump (
        .i_en             (jump_en),
        .i_num            (num),
        .i_sel            (sel),
        .i_func           (func),
        .i_sig_front      (i_sig_front),
        .i_sig_hand       (i_sig_hand),
        .i_sig_processing (i_sig_processing),
        .i_sig_machine    (i_sig_machine),
        .o_taken          (jump_taken),
        .o_target         (jump_target)
    );

    wait_unit u_wait (
        .next_step        (next_step),
        .rst              (rst),
        .i_start          (wait_start),
        .i_num            (num),
        .i_sel            (sel),
        .i_func           (func),
        .i_ms_tick        (i_ms_tick),
        .i_sig_front      (i_sig_front),
        .i_sig_hand       (i_sig_hand),
        .i_sig_processing (i_sig_processing),
        .i_sig_machine    (i_sig_machine),
        .o_done           (wait_done)
    );

endmodule

`default_nettype wire

/* hdl/wait_unit.sv */
//####################################################################
// wait unit
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module wait_unit (
    input  wire logic                          next_step,
    input  wire logic                          rst,
    input  wire logic                          i_start,
    input  wire logic [script_pkg::num_w-1:0]  i_num,
    input  wire logic [script_pkg::sel_w-1:0]  i_sel,
    input  wire logic [script_pkg::func_w-1:0] i_func,
    input  wire logic                          i_ms_tick,
    input  wire logic                          i_sig_front,
    input  wire logic                          i_sig_hand,
    input  wire logic                          i_sig_processing,
    input  wire logic                          i_sig_machine,
    output      logic                          o_done
);
    import script_pkg::*;

    logic              busy;
    logic [num_w-1:0]  remain;
    logic [sel_w-1:0]  sel_q;
    logic [func_w-1:0] func_q;
    logic              cond;

    // live feedback, the latched selector picks the bit
    assign cond = fb_cond(sel_q, i_sig_front, i_sig_hand, i_sig_processing, i_sig_machine);

    // done from cycle after start onward, drops busy on the same edge
    always_comb begin
        case (func_q)
            2'd0:    o_done = busy && (remain == '0);
            2'd1:    o_done = busy && cond;
            default: o_done = busy;
        endcase
    end

    always_ff @(posedge next_step or posedge rst) begin
        if (rst) begin
            busy   <= 1'b0;
            remain <= '0;
        end else if (i_start) begin
            busy   <= 1'b1;
            remain <= i_num;
        end else if (o_done) begin
            busy <= 1'b0;
        end else if (busy && i_ms_tick && (remain != '0)) begin
            // ticks only count once the wait is running
            remain <= remain - 1'b1;
        end
    end

    // wait mode held for the whole wait
    always_ff @(posedge next_step) begin
        if (i_start) begin
            sel_q  <= i_sel;
            func_q <= i_func;
        end
    end

endmodule

`default_nettype wire

/* hdl/jump_unit.sv */
//####################################################################
// jump condition unit
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module jump_unit (
    input  wire logic                          i_en,
    input  wire logic [script_pkg::num_w-1:0]  i_num,
    input  wire logic [script_pkg::sel_w-1:0]  i_sel,
    input  wire logic [script_pkg::func_w-1:0] i_func,
    input  wire logic                          i_sig_front,
    input  wire logic                          i_sig_hand,
    input  wire logic                          i_sig_processing,
    input  wire logic                          i_sig_machine,
    output      logic                          o_taken,
    output      logic [script_pkg::pc_w-1:0]   o_target
);
    import script_pkg::*;

    logic cond;
    logic take;

    assign cond = fb_cond(i_sel, i_sig_front, i_sig_hand, i_sig_processing, i_sig_machine);

    // func 0 always, 1 on condition, 2 on not condition, 3 never
    always_comb begin
        case (i_func)
            2'd0:    take = 1'b1;
            2'd1:    take = cond;
            2'd2:    take = !cond;
            default: take = 1'b0;
        endcase
    end

    assign o_taken  = i_en && take;
    // targets are word aligned
    assign o_target = {i_num[pc_w-1:1], 1'b0};

endmodule

`default_nettype wire

/* hdl/action_formatter.sv */
//####################################################################
// action command formatter
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module action_formatter (
    input  wire logic                          next_step,
    input  wire logic                          rst,
    input  wire logic                          i_en,
    input  wire logic [script_pkg::num_w-1:0]  i_num,
    input  wire logic [script_pkg::func_w-1:0] i_func,
    output      logic                          o_target_valid,
    output      logic [7:0]                    o_target,
    output      logic                          o_operate_valid,
    output      logic [7:0]                    o_operate
);
    import script_pkg::*;

    action_e    act;
    logic [4:0] act_hot;
    logic       act_ok;

    assign act = action_e'(i_num[2:0]);

    // one-hot operation bits, move on top down to get
    always_comb begin
        act_ok  = 1'b1;
        act_hot = 5'b00000;
        case (act)
            act_move:     act_hot = 5'b10000;
            act_throw:    act_hot = 5'b01000;
            act_interact: act_hot = 5'b00100;
            act_put:      act_hot = 5'b00010;
            act_get:      act_hot = 5'b00001;
            default:      act_ok  = 1'b0;
        endcase
    end

    // valid strobes
    always_ff @(posedge next_step or posedge rst) begin
        if (rst) begin
            o_target_valid  <= 1'b0;
            o_operate_valid <= 1'b0;
        end else begin
            o_target_valid  <= i_en && (i_func == 2'd0);
            o_operate_valid <= i_en && (i_func == 2'd1) && act_ok;
        end
    end

    // command bytes, only loaded when a pulse goes out
    always_ff @(posedge next_step) begin
        if (i_en && (i_func == 2'd0)) begin
            // machine id over the target header
            o_target <= {i_num[5:0], hdr_target};
        end
        if (i_en && (i_func == 2'd1) && act_ok) begin
            o_operate <= {1'b0, act_hot, hdr_operate};
        end
    end

endmodule

`default_nettype wire

/* hdl/script_sequencer.sv */
//####################################################################
// script sequencer
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module script_sequencer (
    input  wire logic                          next_step,
    input  wire logic                          rst,
    input  wire logic                          i_start,
    input  wire logic [script_pkg::word_w-1:0] i_rd_data,
    input  wire logic                          i_jump_taken,
    input  wire logic [script_pkg::pc_w-1:0]   i_jump_target,
    input  wire logic                          i_wait_done,
    output      logic [script_pkg::pc_w-1:0]   o_rd_addr,
    output      logic [script_pkg::num_w-1:0]  o_num,
    output      logic [script_pkg::sel_w-1:0]  o_sel,
    output      logic [script_pkg::func_w-1:0] o_func,
    output      logic                          o_act_en,
    output      logic                          o_jump_en,
    output      logic                          o_wait_start,
    output      script_pkg::game_state_e       o_game_state,
    output      logic [script_pkg::pc_w-1:0]   o_pc,
    output      logic                          o_busy,
    output      logic                          o_halted
);
    import script_pkg::*;

    seq_state_e  state;
    script_op_e  op;
    game_state_e game_state;
    logic [pc_w-1:0] pc;

    // sequential advance, carry out means pc ran past the last word
    logic [pc_w:0]   pc_inc;
    logic [pc_w-1:0] adv_pc;
    seq_state_e      adv_state;

    // field split of the word returned for the current pc
    assign o_num  = i_rd_data[15:8];
    assign o_sel  = i_rd_data[7:5];
    assign o_func = i_rd_data[4:3];
    assign op     = script_op_e'(i_rd_data[2:0]);

    assign pc_inc    = {1'b0, pc} + {{(pc_w-1){1'b0}}, 2'b10};
    assign adv_pc    = pc_inc[pc_w] ? pc : pc_inc[pc_w-1:0];
    assign adv_state = pc_inc[pc_w] ? st_halt : st_fetch;

    // one-hot unit enables, exec cycle only
    assign o_act_en     = (state == st_exec) && (op == op_action);
    assign o_jump_en    = (state == st_exec) && (op == op_jump);
    assign o_wait_start = (state == st_exec) && (op == op_wait);

    // memory is read at pc continuously, word valid in exec
    assign o_rd_addr    = pc;
    assign o_pc         = pc;
    assign o_game_state = game_state;
    assign o_busy       = (state != st_idle) && (state != st_halt);
    assign o_halted     = (state == st_halt);

    always_ff @(posedge next_step or posedge rst) begin
        if (rst) begin
            state      <= st_idle;
            pc         <= '0;
            game_state <= gs_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (i_start) begin
                        state <= st_fetch;
                    end
                end
                st_fetch: begin
                    state <= st_exec;
                end
                st_exec: begin
                    case (op)
                        op_jump: begin
                            if (i_jump_taken) begin
                                pc    <= i_jump_target;
                                state <= st_fetch;
                            end else begin
                                pc    <= adv_pc;
                                state <= adv_state;
                            end
                        end
                        op_wait: begin
                            // pc holds until the wait unit reports done
                            state <= st_wait;
                        end
                        op_game: begin
                            game_state <= game_state_e'(o_func);
                            if (game_state_e'(o_func) == gs_finish) begin
                                state <= st_halt;
                            end else begin
                                pc    <= adv_pc;
                                state <= adv_state;
                            end
                        end
                        // action, nop and unused codes just step on
                        default: begin
                            pc    <= adv_pc;
                            state <= adv_state;
                        end
                    endcase
                end
                st_wait: begin
                    if (i_wait_done) begin
                        pc    <= adv_pc;
                        state <= adv_state;
                    end
                end
                st_halt: begin
                    // stays here until reset
                    state <= st_halt;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/script_mem.sv */
//####################################################################
// script memory
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module script_mem (
    input  wire logic                          next_step,
    input  wire logic                          i_we,
    input  wire logic [script_pkg::pc_w-1:0]   i_wr_addr,
    input  wire logic [script_pkg::word_w-1:0] i_wr_data,
    input  wire logic [script_pkg::pc_w-1:0]   i_rd_addr,
    output      logic [script_pkg::word_w-1:0] o_rd_data
);
    import script_pkg::*;

    logic [word_w-1:0] mem [mem_depth];

    // word index is the byte address without bit 0
    logic [pc_w-2:0] wr_idx;
    logic [pc_w-2:0] rd_idx;

    assign wr_idx = i_wr_addr[pc_w-1:1];
    assign rd_idx = i_rd_addr[pc_w-1:1];

    // loading port
    always_ff @(posedge next_step) begin
        if (i_we) begin
            mem[wr_idx] <= i_wr_data;
        end
    end

    // registered read, same-cycle write gives the old word
    always_ff @(posedge next_step) begin
        o_rd_data <= mem[rd_idx];
    end

endmodule

`default_nettype wire

/* hdl/script_pkg.sv */
//####################################################################
// script interpreter shared definitions
//####################################################################
`default_nettype none

package script_pkg;

    // script word fields, msb to lsb: num | sel | func | op
    localparam int num_w     = 8;
    localparam int sel_w     = 3;
    localparam int func_w    = 2;
    localparam int word_w    = 16;
    localparam int mem_depth = 128;
    // byte address, bit 0 always zero
    localparam int pc_w      = $clog2(mem_depth) + 1;

    typedef enum logic [2:0] {
        op_nop    = 3'd0,
        op_action = 3'd1,
        op_jump   = 3'd2,
        op_wait   = 3'd3,
        op_game   = 3'd4
    } script_op_e;

    // low 3 bits of num, codes 5..7 are invalid
    typedef enum logic [2:0] {
        act_move     = 3'd0,
        act_throw    = 3'd1,
        act_interact = 3'd2,
        act_put      = 3'd3,
        act_get      = 3'd4
    } action_e;

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_exec,
        st_wait,
        st_halt
    } seq_state_e;

    // encoding equals the func field of a game word
    typedef enum logic [1:0] {
        gs_idle   = 2'd0,
        gs_run    = 2'd1,
        gs_pause  = 2'd2,
        gs_finish = 2'd3
    } game_state_e;

    localparam logic [1:0] hdr_target  = 2'b01;
    localparam logic [1:0] hdr_operate = 2'b10;

    // feedback condition shared by jump and wait
    // sel[1:0] picks front, hand, processing, machine; sel[2] inverts
    function automatic logic fb_cond(
        input logic [sel_w-1:0] sel,
        input logic             front,
        input logic             hand,
        input logic             processing,
        input logic             machine
    );
        logic [3:0] fb;
        fb = {machine, processing, hand, front};
        return fb[sel[1:0]] ^ sel[2];
    endfunction

endpackage

`default_nettype wire
